//--- hdl/cpu_top.sv
////////////////////////////////////////////////////////////////////////////
// core top: fetch, decode, execute, memory and retire chained in order
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_req,
    input  isa_pkg::instr_t        instr_data,
    output logic                   instr_ack,
    output logic                   trace_valid,
    output trace_pkg::seq_id_t     trace_id,
    output trace_pkg::trace_kind_e trace_kind,
    output isa_pkg::reg_idx_t      trace_rd,
    output isa_pkg::word_t         trace_value
);
    import isa_pkg::*;
    import trace_pkg::*;

    // fetch to decode
    logic     f_valid, stall;
    seq_id_t  f_id;
    instr_t   f_instr;
    // decode to execute
    logic     d_valid;
    seq_id_t  d_id;
    opcode_e  d_op;
    reg_idx_t d_rd;
    word_t    d_a, d_b;
    imm_t     d_imm;
    // execute to memory
    logic     e_valid, ex_busy;
    seq_id_t  e_id;
    opcode_e  e_op;
    reg_idx_t e_rd, ex_busy_rd;
    word_t    e_result, e_store_data;
    // memory to retire
    logic     m_valid, mem_busy;
    seq_id_t  m_id;
    opcode_e  m_op;
    reg_idx_t m_rd, mem_busy_rd;
    word_t    m_value;
    // write-back
    logic     wb_en;
    reg_idx_t wb_idx;
    word_t    wb_data;

    fetch_stage u_fetch (
        .clk, .rst, .instr_req, .instr_data, .instr_ack, .stall,
        .f_valid, .f_id, .f_instr
    );

    decode_stage u_decode (
        .clk, .rst, .f_valid, .f_id, .f_instr, .stall,
        .wb_en, .wb_idx, .wb_data,
        .ex_busy_rd, .mem_busy_rd, .ex_busy, .mem_busy,
        .d_valid, .d_id, .d_op, .d_rd, .d_a, .d_b, .d_imm
    );

    execute_stage u_execute (
        .clk, .rst, .d_valid, .d_id, .d_op, .d_rd, .d_a, .d_b, .d_imm,
        .ex_busy, .ex_busy_rd,
        .e_valid, .e_id, .e_op, .e_rd, .e_result, .e_store_data
    );

    memory_stage u_memory (
        .clk, .rst, .e_valid, .e_id, .e_op, .e_rd, .e_result, .e_store_data,
        .mem_busy, .mem_busy_rd,
        .m_valid, .m_id, .m_op, .m_rd, .m_value
    );

    retire_trace u_retire (
        .clk, .rst, .m_valid, .m_id, .m_op, .m_rd, .m_value,
        .wb_en, .wb_idx, .wb_data,
        .trace_valid, .trace_id, .trace_kind, .trace_rd, .trace_value
    );

endmodule

//--- hdl/decode_stage.sv
////////////////////////////////////////////////////////////////////////////
// decode stage with field split, register file with write-through, hazard
// interlock and the decode/execute pipeline register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               f_valid,
    input  trace_pkg::seq_id_t f_id,
    input  isa_pkg::instr_t    f_instr,
    output logic               stall,
    input  logic               wb_en,
    input  isa_pkg::reg_idx_t  wb_idx,
    input  isa_pkg::word_t     wb_data,
    input  isa_pkg::reg_idx_t  ex_busy_rd,
    input  isa_pkg::reg_idx_t  mem_busy_rd,
    input  logic               ex_busy,
    input  logic               mem_busy,
    output logic               d_valid,
    output trace_pkg::seq_id_t d_id,
    output isa_pkg::opcode_e   d_op,
    output isa_pkg::reg_idx_t  d_rd,
    output isa_pkg::word_t     d_a,
    output isa_pkg::word_t     d_b,
    output isa_pkg::imm_t      d_imm
);
    import isa_pkg::*;

    word_t    regs [NUM_REGS];
    opcode_e  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t src_b;
    imm_t     imm;
    word_t    val_a;
    word_t    val_b;
    logic     hz_a;
    logic     hz_b;

    ////////////////////////////////////////////////////////////////////////////
    // field split
    ////////////////////////////////////////////////////////////////////////////
    assign op  = opcode_e'(f_instr[OP_LSB +: OP_W]);
    assign rd  = f_instr[RD_LSB +: REG_IDX_W];
    assign rs1 = f_instr[RS1_LSB +: REG_IDX_W];
    assign rs2 = f_instr[RS2_LSB +: REG_IDX_W];
    assign imm = f_instr[IMM_LSB +: IMM_W];

    // st sends rd out as store data, so it takes the b port
    assign src_b = (op == OP_ST) ? rd : rs2;

    ////////////////////////////////////////////////////////////////////////////
    // register file
    ////////////////////////////////////////////////////////////////////////////
    // retire write lands this cycle, so bypass it onto the read ports
    assign val_a = (wb_en && (wb_idx == rs1)) ? wb_data : regs[rs1];
    assign val_b = (wb_en && (wb_idx == src_b)) ? wb_data : regs[src_b];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_idx] <= wb_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // interlock
    ////////////////////////////////////////////////////////////////////////////
    // a source matching a pending writer in execute or memory must wait
    // the retire slot needs no wait thanks to the write-through above
    assign hz_a = reads_a(op) &&
                  ((ex_busy && (ex_busy_rd == rs1)) || (mem_busy && (mem_busy_rd == rs1)));
    assign hz_b = reads_b(op) &&
                  ((ex_busy && (ex_busy_rd == src_b)) || (mem_busy && (mem_busy_rd == src_b)));
    assign stall = f_valid && (hz_a || hz_b);

    // issue the instruction or a bubble while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= f_valid && !stall;
        end
    end

    // decode/execute payload
    always_ff @(posedge clk) begin
        d_id  <= f_id;
        d_op  <= op;
        d_rd  <= rd;
        d_a   <= val_a;
        d_b   <= val_b;
        d_imm <= imm;
    end

    // a stalled instruction waits in fetch and nothing issues in its place
    a_no_issue_on_stall: assert property (@(posedge clk) disable iff (rst)
        stall |=> f_valid && $stable(f_id) && !d_valid)
        else $error("stalled instruction was issued or left fetch");

endmodule

//--- hdl/execute_stage.sv
////////////////////////////////////////////////////////////////////////////
// execute: alu and load/store address generation, execute/memory register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               d_valid,
    input  trace_pkg::seq_id_t d_id,
    input  isa_pkg::opcode_e   d_op,
    input  isa_pkg::reg_idx_t  d_rd,
    input  isa_pkg::word_t     d_a,
    input  isa_pkg::word_t     d_b,
    input  isa_pkg::imm_t      d_imm,
    output logic               ex_busy,
    output isa_pkg::reg_idx_t  ex_busy_rd,
    output logic               e_valid,
    output trace_pkg::seq_id_t e_id,
    output isa_pkg::opcode_e   e_op,
    output isa_pkg::reg_idx_t  e_rd,
    output isa_pkg::word_t     e_result,
    output isa_pkg::word_t     e_store_data
);
    import isa_pkg::*;

    word_t imm_ext;
    word_t alu;

    // sign-extend the 7-bit immediate
    assign imm_ext = {{(WORD_W-IMM_W){d_imm[IMM_W-1]}}, d_imm};

    always_comb begin
        case (d_op)
            OP_ADD:  alu = d_a + d_b;
            OP_SUB:  alu = d_a - d_b;
            OP_AND:  alu = d_a & d_b;
            OP_XOR:  alu = d_a ^ d_b;
            // addi result, or effective address for ld and st
            OP_ADDI, OP_LD, OP_ST: alu = d_a + imm_ext;
            default: alu = '0;
        endcase
    end

    // pending destination for the decode interlock
    assign ex_busy    = d_valid && writes_rd(d_op);
    assign ex_busy_rd = d_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            e_valid <= 1'b0;
        end else begin
            e_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        e_id         <= d_id;
        e_op         <= d_op;
        e_rd         <= d_rd;
        e_result     <= alu;
        e_store_data <= d_b;
    end

endmodule

//--- hdl/fetch_stage.sv
////////////////////////////////////////////////////////////////////////////
// four-phase instruction acceptor, tags each instruction with a sequence id
// and holds it until decode takes it
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_req,
    input  isa_pkg::instr_t    instr_data,
    output logic               instr_ack,
    input  logic               stall,
    output logic               f_valid,
    output trace_pkg::seq_id_t f_id,
    output isa_pkg::instr_t    f_instr
);
    import trace_pkg::*;

    typedef enum logic {
        WAIT_REQ,
        WAIT_DROP
    } fetch_state_e;

    fetch_state_e state;
    seq_id_t      next_id;
    logic         take;

    // capture only when the holding register is free or leaving this cycle
    assign take      = (state == WAIT_REQ) && instr_req && !stall;
    // ack is high for the whole second half of the handshake
    assign instr_ack = (state == WAIT_DROP);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= WAIT_REQ;
            f_valid <= 1'b0;
            next_id <= '0;
        end else begin
            case (state)
                WAIT_REQ: begin
                    if (take) begin
                        state <= WAIT_DROP;
                    end
                end
                WAIT_DROP: begin
                    // source dropped req, release ack
                    if (!instr_req) begin
                        state <= WAIT_REQ;
                    end
                end
                default: state <= WAIT_REQ;
            endcase
            // holding register fills on capture, empties when decode moves on
            if (take) begin
                f_valid <= 1'b1;
                next_id <= next_id + 1'b1;
            end else if (!stall) begin
                f_valid <= 1'b0;
            end
        end
    end

    // instruction payload and its id
    always_ff @(posedge clk) begin
        if (take) begin
            f_instr <= instr_data;
            f_id    <= next_id;
        end
    end

    // the source must drop req before ack may fall
    a_ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(instr_ack) |-> !instr_req)
        else $error("instr_ack fell while instr_req was high");

endmodule

//--- hdl/isa_pkg.sv
////////////////////////////////////////////////////////////////////////////
// instruction set of the 16-bit core: widths, opcodes, fields and sizes
// imported by every pipeline stage that decodes or moves instructions
////////////////////////////////////////////////////////////////////////////
package isa_pkg;

    // data path and field widths
    localparam int WORD_W     = 16;
    localparam int INSTR_W    = 16;
    localparam int OP_W       = 3;
    localparam int REG_IDX_W  = 3;
    localparam int IMM_W      = 7;
    localparam int RAM_ADDR_W = 4;

    // storage sizes
    localparam int NUM_REGS  = 8;
    localparam int RAM_WORDS = 16;

    // field positions, lsb of each field
    // imm shares bits 6..0 with rs2
    localparam int OP_LSB  = 13;
    localparam int RD_LSB  = 10;
    localparam int RS1_LSB = 7;
    localparam int RS2_LSB = 4;
    localparam int IMM_LSB = 0;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [INSTR_W-1:0]    instr_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [IMM_W-1:0]      imm_t;
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

    typedef enum logic [OP_W-1:0] {
        OP_NOP  = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_AND  = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5,
        OP_LD   = 3'd6,
        OP_ST   = 3'd7
    } opcode_e;

    // ops that write rd at retire
    function automatic logic writes_rd(opcode_e op);
        return (op != OP_NOP) && (op != OP_ST);
    endfunction

    // ops that read rs1 as operand a
    function automatic logic reads_a(opcode_e op);
        return op != OP_NOP;
    endfunction

    // ops that read a second register, rs2 for alu ops, rd for st
    function automatic logic reads_b(opcode_e op);
        return (op == OP_ADD) || (op == OP_SUB) || (op == OP_AND) ||
               (op == OP_XOR) || (op == OP_ST);
    endfunction

endpackage

//--- hdl/memory_stage.sv
////////////////////////////////////////////////////////////////////////////
// memory: 16-word data ram for ld and st, memory/retire register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module memory_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               e_valid,
    input  trace_pkg::seq_id_t e_id,
    input  isa_pkg::opcode_e   e_op,
    input  isa_pkg::reg_idx_t  e_rd,
    input  isa_pkg::word_t     e_result,
    input  isa_pkg::word_t     e_store_data,
    output logic               mem_busy,
    output isa_pkg::reg_idx_t  mem_busy_rd,
    output logic               m_valid,
    output trace_pkg::seq_id_t m_id,
    output isa_pkg::opcode_e   m_op,
    output isa_pkg::reg_idx_t  m_rd,
    output isa_pkg::word_t     m_value
);
    import isa_pkg::*;

    word_t     ram [RAM_WORDS];
    ram_addr_t addr;

    // address wraps inside the 16 words
    assign addr = e_result[RAM_ADDR_W-1:0];

    assign mem_busy    = e_valid && writes_rd(e_op);
    assign mem_busy_rd = e_rd;

    // data ram, cleared with the core
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else if (e_valid && (e_op == OP_ST)) begin
            ram[addr] <= e_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else begin
            m_valid <= e_valid;
        end
    end

    // loads read ram, stores report their data, alu results pass through
    always_ff @(posedge clk) begin
        m_id <= e_id;
        m_op <= e_op;
        m_rd <= e_rd;
        case (e_op)
            OP_LD:   m_value <= ram[addr];
            OP_ST:   m_value <= e_store_data;
            default: m_value <= e_result;
        endcase
    end

endmodule

//--- hdl/retire_trace.sv
////////////////////////////////////////////////////////////////////////////
// retire: register write-back and one trace record per retired instruction
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module retire_trace (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   m_valid,
    input  trace_pkg::seq_id_t     m_id,
    input  isa_pkg::opcode_e       m_op,
    input  isa_pkg::reg_idx_t      m_rd,
    input  isa_pkg::word_t         m_value,
    output logic                   wb_en,
    output isa_pkg::reg_idx_t      wb_idx,
    output isa_pkg::word_t         wb_data,
    output logic                   trace_valid,
    output trace_pkg::seq_id_t     trace_id,
    output trace_pkg::trace_kind_e trace_kind,
    output isa_pkg::reg_idx_t      trace_rd,
    output isa_pkg::word_t         trace_value
);
    import isa_pkg::*;
    import trace_pkg::*;

    seq_id_t     exp_id;
    trace_kind_e kind;

    // write-back goes straight to the register file this cycle
    assign wb_en   = m_valid && writes_rd(m_op);
    assign wb_idx  = m_rd;
    assign wb_data = m_value;

    assign kind = writes_rd(m_op) ? TR_REG :
                  (m_op == OP_ST) ? TR_STORE : TR_NONE;

    // record strobe and the next id expected to retire
    always_ff @(posedge clk) begin
        if (rst) begin
            trace_valid <= 1'b0;
            exp_id      <= '0;
        end else begin
            trace_valid <= m_valid;
            if (m_valid) begin
                exp_id <= exp_id + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        trace_id    <= m_id;
        trace_kind  <= kind;
        trace_rd    <= m_rd;
        trace_value <= m_value;
    end

    // ids assigned at fetch must come back in order with no gaps
    a_in_order: assert property (@(posedge clk) disable iff (rst)
        m_valid |-> (m_id == exp_id))
        else $error("retired id %0d, expected %0d", m_id, exp_id);

endmodule

//--- hdl/trace_pkg.sv
////////////////////////////////////////////////////////////////////////////
// retire trace record types: sequence id and record kind
////////////////////////////////////////////////////////////////////////////
package trace_pkg;

    // id width, wraps around after 256 instructions
    localparam int SEQ_ID_W     = 8;
    localparam int TRACE_KIND_W = 2;

    typedef logic [SEQ_ID_W-1:0] seq_id_t;

    // what a retired instruction did
    // TR_REG   register written, value is the result
    // TR_STORE ram written, value is the store data
    // TR_NONE  nop, nothing changed
    typedef enum logic [TRACE_KIND_W-1:0] {
        TR_NONE  = 2'd0,
        TR_REG   = 2'd1,
        TR_STORE = 2'd2
    } trace_kind_e;

endpackage

//--- sim/cpu_tb.sv
////////////////////////////////////////////////////////////////////////////
// drives the 16-bit core over its four-phase instruction port and checks
// every trace record against an ISA reference model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_tb;
    import isa_pkg::*;
    import trace_pkg::*;

    localparam int RESET_CYCLES = 8;
    // instructions per test phase
    localparam int N_SEED  = 8;
    localparam int N_ALU   = 32;
    localparam int N_CHAIN = 24;
    localparam int N_LDST  = 32;
    localparam int N_MIX   = 104;
    localparam int NUM_INSTR = N_SEED + N_ALU + N_CHAIN + N_LDST + N_MIX;
    // worst case per instruction is random delays, stall and both handshake halves
    localparam int CYCLES_PER_INSTR = 12;
    localparam int TIMEOUT_CYCLES   = NUM_INSTR * CYCLES_PER_INSTR + 1600;
    // last send returns before its record, allow the pipeline depth and a stall
    localparam int DRAIN_CYCLES = 16;

    // phase tags carried with each sent instruction
    localparam int T_SEED  = 0;
    localparam int T_ALU   = 1;
    localparam int T_CHAIN = 2;
    localparam int T_LDST  = 3;
    localparam int T_MIX   = 4;

    // expected trace record of one instruction
    typedef struct packed {
        trace_kind_e kind;
        reg_idx_t    rd;
        word_t       value;
    } exp_rec_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_req;
    instr_t      instr_data;
    logic        instr_ack;
    logic        trace_valid;
    seq_id_t     trace_id;
    trace_kind_e trace_kind;
    reg_idx_t    trace_rd;
    word_t       trace_value;

    logic [31:0] rng;
    instr_t      sent_q [$];
    int          tag_q [$];
    // architectural state of the reference model
    word_t       model_regs [NUM_REGS];
    word_t       model_ram [RAM_WORDS];
    seq_id_t     exp_id = '0;
    int          retired = 0;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    logic        prev_ack = 1'b0;

    cpu_top uut (
        .clk, .rst, .instr_req, .instr_data, .instr_ack,
        .trace_valid, .trace_id, .trace_kind, .trace_rd, .trace_value
    );

    initial begin
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift(rng);
        r = rng;
    endtask

    function automatic string test_name(input int tag);
        case (tag)
            T_SEED:  return "addi_seed";
            T_ALU:   return "alu";
            T_CHAIN: return "raw_chain";
            T_LDST:  return "ld_st";
            default: return "random_mix";
        endcase
    endfunction

    // register form leaves the low four bits zero
    function automatic instr_t encode_reg(input opcode_e op, input reg_idx_t rd,
                                          input reg_idx_t rs1, input reg_idx_t rs2);
        return {op, rd, rs1, rs2, 4'b0000};
    endfunction

    function automatic instr_t encode_imm(input opcode_e op, input reg_idx_t rd,
                                          input reg_idx_t rs1, input imm_t imm);
        return {op, rd, rs1, imm};
    endfunction

    function automatic opcode_e pick_alu_op(input logic [1:0] sel);
        case (sel)
            2'd0:    return OP_ADD;
            2'd1:    return OP_SUB;
            2'd2:    return OP_AND;
            default: return OP_XOR;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model that runs one instruction in program order
    ////////////////////////////////////////////////////////////////////////////
    function automatic exp_rec_t ref_exec(input instr_t ins);
        exp_rec_t   rec;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
        word_t      imm_ext;
        word_t      ea;
        logic [3:0] addr;
        rd = ins[12:10];
        a = model_regs[ins[9:7]];
        b = model_regs[ins[6:4]];
        imm_ext = {{9{ins[6]}}, ins[6:0]};
        // effective address wraps inside the 16 ram words
        ea = a + imm_ext;
        addr = ea[3:0];
        rec.kind = TR_REG;
        rec.rd = rd;
        rec.value = '0;
        case (ins[15:13])
            OP_ADD:  rec.value = a + b;
            OP_SUB:  rec.value = a - b;
            OP_AND:  rec.value = a & b;
            OP_XOR:  rec.value = a ^ b;
            OP_ADDI: rec.value = a + imm_ext;
            OP_LD:   rec.value = model_ram[addr];
            OP_ST: begin
                // store data comes from the rd register
                rec.kind = TR_STORE;
                rec.value = model_regs[rd];
                model_ram[addr] = model_regs[rd];
            end
            default: rec.kind = TR_NONE;
        endcase
        if (rec.kind == TR_REG) begin
            model_regs[rd] = rec.value;
        end
        return rec;
    endfunction

    task automatic check_field(input string test, input string field,
                               input logic [15:0] exp_v, input logic [15:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            errors++;
            $display("Mismatch %s %s: expected %0h, actual %0h", test, field, exp_v, act_v);
        end
    endtask

    // one full four-phase transfer with random gaps on both sides
    task automatic send_instr(input instr_t ins, input int tag);
        logic [31:0] r;
        next_rand(r);
        repeat (r[1:0]) @(posedge clk);
        @(posedge clk);
        instr_req <= 1'b1;
        instr_data <= ins;
        sent_q.push_back(ins);
        tag_q.push_back(tag);
        do @(negedge clk); while (instr_ack !== 1'b1);
        next_rand(r);
        repeat (r[1:0]) @(posedge clk);
        @(posedge clk);
        instr_req <= 1'b0;
        do @(negedge clk); while (instr_ack !== 1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] r;
        reg_idx_t    prev_rd;
        imm_t        st_imm;
        imm_t        ld_imm;
        int          drain;
        rst = 1'b1;
        instr_req = 1'b0;
        instr_data = '0;
        rng = 32'd34;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            model_ram[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // give every register a random value
        for (int i = 0; i < N_SEED; i++) begin
            next_rand(r);
            send_instr(encode_imm(OP_ADDI, i[2:0], i[2:0], r[6:0]), T_SEED);
        end
        for (int i = 0; i < N_ALU; i++) begin
            next_rand(r);
            send_instr(encode_reg(pick_alu_op(r[1:0]), r[4:2], r[7:5], r[10:8]), T_ALU);
        end
        // each instruction reads the rd of the one before it
        prev_rd = 3'd1;
        for (int i = 0; i < N_CHAIN; i++) begin
            next_rand(r);
            if (r[3:2] == 2'd0) begin
                send_instr(encode_imm(OP_ADDI, r[6:4], prev_rd, r[13:7]), T_CHAIN);
            end else begin
                send_instr(encode_reg(pick_alu_op(r[1:0]), r[6:4], prev_rd, prev_rd), T_CHAIN);
            end
            prev_rd = r[6:4];
        end
        // st then ld to the same offset or another with immediates in -8..7
        for (int i = 0; i < N_LDST / 2; i++) begin
            next_rand(r);
            st_imm = {{3{r[9]}}, r[9:6]};
            ld_imm = r[10] ? st_imm : {{3{r[14]}}, r[14:11]};
            send_instr(encode_imm(OP_ST, r[5:3], r[2:0], st_imm), T_LDST);
            send_instr(encode_imm(OP_LD, r[17:15], r[2:0], ld_imm), T_LDST);
        end
        // any 16-bit word is a legal instruction
        for (int i = 0; i < N_MIX; i++) begin
            next_rand(r);
            send_instr(r[15:0], T_MIX);
        end

        // wait for the outstanding records, at most the drain window
        drain = 0;
        while ((sent_q.size() != 0) && (drain < DRAIN_CYCLES)) begin
            @(negedge clk);
            drain++;
        end
        // leave room for a stray extra record
        repeat (10) @(negedge clk);
        assert (retired == NUM_INSTR) else begin
            errors++;
            $display("only %0d of %0d instructions retired", retired, NUM_INSTR);
        end
        $display("records %0d, checks %0d, errors %0d", retired, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checkers sample on the falling edge
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin : compare
        instr_t   ins;
        int       tag;
        exp_rec_t rec;
        if (!rst && trace_valid) begin
            assert (sent_q.size() != 0) else begin
                errors++;
                $display("trace record id %0d arrived with no instruction outstanding",
                         trace_id);
            end
            if (sent_q.size() != 0) begin
                ins = sent_q.pop_front();
                tag = tag_q.pop_front();
                rec = ref_exec(ins);
                check_field(test_name(tag), "trace_id", {8'b0, exp_id}, {8'b0, trace_id});
                check_field(test_name(tag), "trace_kind", {14'b0, rec.kind}, {14'b0, trace_kind});
                check_field(test_name(tag), "trace_rd", {13'b0, rec.rd}, {13'b0, trace_rd});
                // a nop carries no value
                if (rec.kind != TR_NONE) begin
                    check_field(test_name(tag), "trace_value", rec.value, trace_value);
                end
                exp_id = exp_id + 1'b1;
                retired++;
            end
        end
    end

    // reset outputs and the ack release rule
    always @(negedge clk) begin
        if (rst) begin
            assert ((instr_ack === 1'b0) && (trace_valid === 1'b0)) else begin
                errors++;
                $display("instr_ack or trace_valid was not low during reset");
            end
        end else if (prev_ack && !instr_ack) begin
            assert (instr_req === 1'b0) else begin
                errors++;
                $display("instr_ack fell while instr_req was still high");
            end
        end
        prev_ack = instr_ack;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d retired, errors %0d",
                     cycles, retired, NUM_INSTR, errors);
            $display("Test failed");
            $finish;
        end
    end

endmodule

//--- src.f
hdl/isa_pkg.sv
hdl/trace_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/retire_trace.sv
hdl/cpu_top.sv
sim/cpu_tb.sv
